// ==== logic/muldiv_pkg.sv ====
// shared types and constants for the iterative multiply/divide subsystem
// operands are 32 bits, results 64 bits, tags TAG_W bits

package muldiv_pkg;

  // ----------------------------------------------------------------------
  // sizes and credit counts
  // ----------------------------------------------------------------------

  localparam int TAG_W        = 4;
  // request buffer depth, equal to the credits the requester starts with
  localparam int REQ_CREDITS  = 2;
  // free response slots assumed at the consumer after reset
  localparam int RESP_CREDITS = 4;
  localparam int ITER_COUNT   = 32;

  // derived widths
  localparam int REQ_PTR_W    = $clog2(REQ_CREDITS);
  localparam int RESP_CNT_W   = $clog2(RESP_CREDITS + 1);
  localparam int ITER_W       = $clog2(ITER_COUNT);

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  // op selects the unit, and for divide also the signedness
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_t;

  // 70 bits
  typedef struct packed {
    muldiv_op_t       op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [TAG_W-1:0] tag;
  } muldiv_req_t;

  // 68 bits; divide packs {remainder, quotient} into result
  typedef struct packed {
    logic [63:0]      result;
    logic [TAG_W-1:0] tag;
  } muldiv_resp_t;

  // common FSM encoding of both arithmetic units
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } unit_state_t;

endpackage

// ==== logic/muldiv_unit_if.sv ====
// link between the request queue, one arithmetic unit and the arbiter
// start is a one-cycle pulse and only comes while busy is low

`timescale 1ns/1ps

interface muldiv_unit_if;

  // request side
  logic                           start;
  logic [31:0]                    a;
  logic [31:0]                    b;
  muldiv_pkg::muldiv_op_t         op;
  logic [muldiv_pkg::TAG_W-1:0]   tag;
  logic                           busy;

  // response side, done and resp stay steady until ack
  logic                           done;
  muldiv_pkg::muldiv_resp_t       resp;
  logic                           ack;

  modport queue (
    output start, a, b, op, tag,
    input  busy
  );

  modport unit (
    input  start, a, b, op, tag, ack,
    output busy, done, resp
  );

  modport arbiter (
    input  done, resp,
    output ack
  );

endinterface

// ==== logic/int_mul_iterative.sv ====
// signed shift-add multiplier, one result bit per cycle over ITER_COUNT cycles
// full 64-bit signed product; op on the interface is not looked at

`timescale 1ns/1ps

module int_mul_iterative (
  input  logic         clk,
  input  logic         reset,
  muldiv_unit_if.unit  unit
);

  logic                     load;
  logic                     shift;
  logic                     hold;
  muldiv_pkg::muldiv_resp_t dpath_resp;

  // sequencing
  int_mul_iterative_ctrl ctrl (
    .clk   (clk),
    .reset (reset),
    .start (unit.start),
    .busy  (unit.busy),
    .done  (unit.done),
    .ack   (unit.ack),
    .load  (load),
    .shift (shift),
    .hold  (hold)
  );

  // operand registers and accumulator
  int_mul_iterative_dpath dpath (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .shift (shift),
    .a     (unit.a),
    .b     (unit.b),
    .tag   (unit.tag),
    .resp  (dpath_resp)
  );

  // result bus only carries data while the answer is being held
  assign unit.resp = hold ? dpath_resp : '0;

endmodule

// ----------------------------------------------------------------------
// control
// ----------------------------------------------------------------------

module int_mul_iterative_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic done,
  input  logic ack,
  output logic load,
  output logic shift,
  output logic hold
);

  muldiv_pkg::unit_state_t          state;
  logic [muldiv_pkg::ITER_W-1:0]    count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::ST_IDLE: begin
          if (start) begin
            state <= muldiv_pkg::ST_CALC;
            count <= '0;
          end
        end
        muldiv_pkg::ST_CALC: begin
          // last iteration lands at count == ITER_COUNT-1
          if (count == muldiv_pkg::ITER_W'(muldiv_pkg::ITER_COUNT - 1)) begin
            state <= muldiv_pkg::ST_DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::ST_DONE: begin
          if (ack) begin
            state <= muldiv_pkg::ST_IDLE;
          end
        end
        default: state <= muldiv_pkg::ST_IDLE;
      endcase
    end
  end

  always_comb begin
    busy  = (state != muldiv_pkg::ST_IDLE);
    done  = (state == muldiv_pkg::ST_DONE);
    hold  = (state == muldiv_pkg::ST_DONE);
    // operands captured on the start edge
    load  = (state == muldiv_pkg::ST_IDLE) && start;
    // one add/shift step every calc cycle
    shift = (state == muldiv_pkg::ST_CALC);
  end

endmodule

// ----------------------------------------------------------------------
// datapath
// ----------------------------------------------------------------------

module int_mul_iterative_dpath (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load,
  input  logic                          shift,
  input  logic [31:0]                   a,
  input  logic [31:0]                   b,
  input  logic [muldiv_pkg::TAG_W-1:0]  tag,
  output muldiv_pkg::muldiv_resp_t      resp
);

  logic [63:0]                   mcand;
  logic [31:0]                   mplier;
  logic [63:0]                   acc;
  logic                          sign_a;
  logic                          sign_b;
  logic [muldiv_pkg::TAG_W-1:0]  tag_q;
  logic [31:0]                   mag_a;
  logic [31:0]                   mag_b;

  // magnitudes; 0x80000000 maps to 2^31, still right as unsigned
  assign mag_a = a[31] ? (~a + 32'd1) : a;
  assign mag_b = b[31] ? (~b + 32'd1) : b;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc    <= '0;
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else if (load) begin
      acc    <= '0;
      sign_a <= a[31];
      sign_b <= b[31];
    end else if (shift && mplier[0]) begin
      acc    <= acc + mcand;
    end
  end

  // operand shift registers and tag
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {32'd0, mag_a};
      mplier <= mag_b;
      tag_q  <= tag;
    end else if (shift) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // negate when exactly one operand was negative
  assign resp.result = (sign_a ^ sign_b) ? (~acc + 64'd1) : acc;
  assign resp.tag    = tag_q;

endmodule

// ==== logic/int_div_iterative.sv ====
// restoring divider, signed (OP_DIV) or unsigned (OP_DIVU), ITER_COUNT steps
// result is {remainder, quotient}; x/0 gives all-ones quotient, remainder x

`timescale 1ns/1ps

module int_div_iterative (
  input  logic         clk,
  input  logic         reset,
  muldiv_unit_if.unit  unit
);

  muldiv_pkg::unit_state_t          state;
  logic [muldiv_pkg::ITER_W-1:0]    count;

  logic                             is_signed;
  logic [31:0]                      mag_a;
  logic [31:0]                      mag_b;
  logic                             rem_neg;
  logic                             quo_neg;
  logic [31:0]                      divisor;
  logic [31:0]                      rem;
  // dividend shifts out of the top while quotient bits shift in
  logic [31:0]                      quo;
  logic [muldiv_pkg::TAG_W-1:0]     tag_q;
  logic [32:0]                      shifted;
  logic                             fits;
  logic [31:0]                      rem_out;
  logic [31:0]                      quo_out;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::ST_IDLE: begin
          if (unit.start) begin
            state <= muldiv_pkg::ST_CALC;
            count <= '0;
          end
        end
        muldiv_pkg::ST_CALC: begin
          if (count == muldiv_pkg::ITER_W'(muldiv_pkg::ITER_COUNT - 1)) begin
            state <= muldiv_pkg::ST_DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::ST_DONE: begin
          if (unit.ack) begin
            state <= muldiv_pkg::ST_IDLE;
          end
        end
        default: state <= muldiv_pkg::ST_IDLE;
      endcase
    end
  end

  assign unit.busy = (state != muldiv_pkg::ST_IDLE);
  assign unit.done = (state == muldiv_pkg::ST_DONE);

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  assign is_signed = (unit.op == muldiv_pkg::OP_DIV);
  // unsigned ops take the raw operands
  assign mag_a = (is_signed && unit.a[31]) ? (~unit.a + 32'd1) : unit.a;
  assign mag_b = (is_signed && unit.b[31]) ? (~unit.b + 32'd1) : unit.b;

  // next partial remainder before the trial subtraction
  assign shifted = {rem, quo[31]};
  assign fits    = (shifted >= {1'b0, divisor});

  always_ff @(posedge clk) begin
    if (state == muldiv_pkg::ST_IDLE && unit.start) begin
      divisor <= mag_b;
      rem     <= '0;
      quo     <= mag_a;
      tag_q   <= unit.tag;
      // remainder takes the dividend sign
      rem_neg <= is_signed && unit.a[31];
      // a zero divisor keeps the all-ones quotient as it is
      quo_neg <= is_signed && (unit.a[31] ^ unit.b[31]) && (unit.b != 32'd0);
    end else if (state == muldiv_pkg::ST_CALC) begin
      if (fits) begin
        rem <= shifted[31:0] - divisor;
      end else begin
        rem <= shifted[31:0];
      end
      quo <= {quo[30:0], fits};
    end
  end

  // sign fix-up; min / -1 wraps back to 0x80000000 with remainder 0
  assign rem_out = rem_neg ? (~rem + 32'd1) : rem;
  assign quo_out = quo_neg ? (~quo + 32'd1) : quo;

  assign unit.resp.result = {rem_out, quo_out};
  assign unit.resp.tag    = tag_q;

endmodule

// ==== logic/muldiv_req_queue.sv ====
// two-entry in-order request buffer in front of the multiplier and divider
// never refuses a write; the requester's credits keep it from overflowing

`timescale 1ns/1ps

module muldiv_req_queue (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  input  muldiv_pkg::muldiv_req_t req,
  output logic                    req_credit,
  muldiv_unit_if.queue            mul,
  muldiv_unit_if.queue            div
);

  muldiv_pkg::muldiv_req_t              entries [muldiv_pkg::REQ_CREDITS];
  // extra top bit tells full from empty
  logic [muldiv_pkg::REQ_PTR_W:0]       wr_ptr;
  logic [muldiv_pkg::REQ_PTR_W:0]       rd_ptr;
  muldiv_pkg::muldiv_req_t              head;
  logic                                 empty;
  logic                                 head_is_mul;
  logic                                 target_busy;
  logic                                 dispatch;

  // storage
  always_ff @(posedge clk) begin
    if (req_val) begin
      entries[wr_ptr[muldiv_pkg::REQ_PTR_W-1:0]] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_val) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (dispatch) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // head decode and dispatch
  // ----------------------------------------------------------------------

  assign head        = entries[rd_ptr[muldiv_pkg::REQ_PTR_W-1:0]];
  assign empty       = (wr_ptr == rd_ptr);
  assign head_is_mul = (head.op == muldiv_pkg::OP_MUL);
  // a busy target stalls everything behind the head
  assign target_busy = head_is_mul ? mul.busy : div.busy;
  assign dispatch    = !empty && !target_busy;

  // credit goes back the cycle the entry leaves
  assign req_credit = dispatch;

  assign mul.start = dispatch && head_is_mul;
  assign mul.a     = head.a;
  assign mul.b     = head.b;
  assign mul.op    = head.op;
  assign mul.tag   = head.tag;

  assign div.start = dispatch && !head_is_mul;
  assign div.a     = head.a;
  assign div.b     = head.b;
  assign div.op    = head.op;
  assign div.tag   = head.tag;

endmodule

// ==== logic/muldiv_resp_arbiter.sv ====
// picks one finished unit per cycle, multiplier first, while credits remain
// output is registered, so a send lands the cycle after done is seen

`timescale 1ns/1ps

module muldiv_resp_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  muldiv_unit_if.arbiter            mul,
  muldiv_unit_if.arbiter            div,
  input  logic                      resp_credit,
  output logic                      resp_val,
  output muldiv_pkg::muldiv_resp_t  resp
);

  logic [muldiv_pkg::RESP_CNT_W-1:0]  credit_cnt;
  logic                               credit_ok;
  logic                               mul_ack_q;
  logic                               div_ack_q;
  logic                               mul_sel;
  logic                               div_sel;
  logic                               send;

  assign credit_ok = (credit_cnt != '0);

  // a unit being acked this cycle still shows done, skip it
  assign mul_sel = credit_ok && mul.done && !mul_ack_q;
  assign div_sel = credit_ok && div.done && !div_ack_q && !mul_sel;
  assign send    = mul_sel || div_sel;

  // ----------------------------------------------------------------------
  // control state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= muldiv_pkg::RESP_CNT_W'(muldiv_pkg::RESP_CREDITS);
      resp_val   <= 1'b0;
      mul_ack_q  <= 1'b0;
      div_ack_q  <= 1'b0;
    end else begin
      // send and returned credit in one cycle cancel out
      credit_cnt <= credit_cnt
                  - {{(muldiv_pkg::RESP_CNT_W-1){1'b0}}, send}
                  + {{(muldiv_pkg::RESP_CNT_W-1){1'b0}}, resp_credit};
      resp_val   <= send;
      mul_ack_q  <= mul_sel;
      div_ack_q  <= div_sel;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (mul_sel) begin
      resp <= mul.resp;
    end else if (div_sel) begin
      resp <= div.resp;
    end
  end

  // ack coincides with resp_val, unit goes idle at that edge
  assign mul.ack = mul_ack_q;
  assign div.ack = div_ack_q;

endmodule

// ==== logic/muldiv_top.sv ====
// multiply/divide subsystem with credit flow control on both sides
// responses can leave out of order; match them by tag

`timescale 1ns/1ps

module muldiv_top (
  input  logic                          clk,
  input  logic                          reset,
  // request side
  input  logic                          req_val,
  input  muldiv_pkg::muldiv_op_t        req_op,
  input  logic [31:0]                   req_a,
  input  logic [31:0]                   req_b,
  input  logic [muldiv_pkg::TAG_W-1:0]  req_tag,
  output logic                          req_credit,
  // response side
  output logic                          resp_val,
  output logic [63:0]                   resp_result,
  output logic [muldiv_pkg::TAG_W-1:0]  resp_tag,
  input  logic                          resp_credit
);

  muldiv_pkg::muldiv_req_t  req;
  muldiv_pkg::muldiv_resp_t resp;

  // one link per arithmetic unit
  muldiv_unit_if mul_if ();
  muldiv_unit_if div_if ();

  assign req.op  = req_op;
  assign req.a   = req_a;
  assign req.b   = req_b;
  assign req.tag = req_tag;

  muldiv_req_queue u_req_queue (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req        (req),
    .req_credit (req_credit),
    .mul        (mul_if.queue),
    .div        (div_if.queue)
  );

  int_mul_iterative u_mul (
    .clk   (clk),
    .reset (reset),
    .unit  (mul_if.unit)
  );

  int_div_iterative u_div (
    .clk   (clk),
    .reset (reset),
    .unit  (div_if.unit)
  );

  muldiv_resp_arbiter u_resp_arb (
    .clk         (clk),
    .reset       (reset),
    .mul         (mul_if.arbiter),
    .div         (div_if.arbiter),
    .resp_credit (resp_credit),
    .resp_val    (resp_val),
    .resp        (resp)
  );

  assign resp_result = resp.result;
  assign resp_tag    = resp.tag;

endmodule

// ==== tb/muldiv_tb.sv ====
// testbench for muldiv_top; reads tb/muldiv_patterns.txt relative to the project root
// runs credit flow control on both sides and checks responses by tag, in any order

`timescale 1ns/1ps

module muldiv_tb;

  localparam int NUM_PATTERNS = 30;
  // op, a, b, expected high word, expected low word
  localparam int WORDS_PER_PATTERN = 5;
  localparam int NUM_TAGS = 1 << muldiv_pkg::TAG_W;
  localparam int WATCHDOG_NS = 40 * NUM_PATTERNS * 10 + 2000;

  logic                          clk;
  logic                          reset;
  logic                          req_val;
  muldiv_pkg::muldiv_op_t        req_op;
  logic [31:0]                   req_a;
  logic [31:0]                   req_b;
  logic [muldiv_pkg::TAG_W-1:0]  req_tag;
  logic                          req_credit;
  logic                          resp_val;
  logic [63:0]                   resp_result;
  logic [muldiv_pkg::TAG_W-1:0]  resp_tag;
  logic                          resp_credit;

  logic [31:0]                   pattern_mem [NUM_PATTERNS*WORDS_PER_PATTERN];
  // scoreboard indexed by tag
  logic [63:0]                   expected_sb [NUM_TAGS];
  logic                          pending [NUM_TAGS];

  logic [muldiv_pkg::TAG_W-1:0]  next_tag;
  int                            sent;
  int                            received;
  int                            req_credits;
  // mirror of the arbiter's response credit counter
  int                            resp_credit_mirror;
  // responses taken in but not yet credited back
  int                            owed;
  // set once every credit is spent, cleared when all are back
  logic                          draining;
  logic                          credit_last;
  logic [15:0]                   lfsr;
  int                            value_errors;
  int                            tag_errors;
  int                            protocol_errors;

  muldiv_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_tag     (req_tag),
    .req_credit  (req_credit),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_tag    (resp_tag),
    .resp_credit (resp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // 16-bit Galois LFSR, taps x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  task automatic compare_resp(input muldiv_pkg::muldiv_resp_t got, input logic [63:0] expected);
    if (got.result !== expected) begin
      $display("Error at %0t ns: resp_result (tag %0d) got %h expected %h",
               $time, got.tag, got.result, expected);
      value_errors++;
    end
  endtask

  task automatic compare_tag(input logic [muldiv_pkg::TAG_W-1:0] tag);
    if (pending[tag] !== 1'b1) begin
      $display("at %0t ns a response came back with tag %0d, which has no request pending",
               $time, tag);
      tag_errors++;
    end
  endtask

  // response side, sampled mid-cycle while outputs are stable
  task automatic collect_response();
    muldiv_pkg::muldiv_resp_t got;
    if (resp_val === 1'b1) begin
      got.result = resp_result;
      got.tag    = resp_tag;
      if (resp_credit_mirror <= 0) begin
        $display("at %0t ns a response was sent while the DUT held no response credit",
                 $time);
        protocol_errors++;
      end else begin
        resp_credit_mirror--;
      end
      compare_tag(got.tag);
      if (pending[got.tag] === 1'b1) begin
        compare_resp(got, expected_sb[got.tag]);
        pending[got.tag] = 1'b0;
        received++;
      end
      owed++;
    end
  endtask

  // one LFSR bit per cycle decides whether a credit goes back
  // credits stay back until the DUT has spent all of them, so its counter hits zero
  task automatic return_resp_credit();
    logic take;
    // last cycle's pulse reaches the arbiter's counter at this edge
    if (credit_last) begin
      resp_credit_mirror++;
    end
    if (owed >= muldiv_pkg::RESP_CREDITS) begin
      draining = 1'b1;
    end else if (owed == 0) begin
      draining = 1'b0;
    end
    take = lfsr[0];
    lfsr = lfsr_next(lfsr);
    if (draining && owed > 0 && take) begin
      resp_credit = 1'b1;
      credit_last = 1'b1;
      owed--;
    end else begin
      resp_credit = 1'b0;
      credit_last = 1'b0;
    end
  endtask

  // issue the next pattern when a credit and a free tag are at hand
  task automatic issue_request();
    int base;
    if (sent < NUM_PATTERNS && req_credits > 0 && pending[next_tag] !== 1'b1) begin
      base = sent * WORDS_PER_PATTERN;
      req_val = 1'b1;
      req_op  = muldiv_pkg::muldiv_op_t'(pattern_mem[base][1:0]);
      req_a   = pattern_mem[base+1];
      req_b   = pattern_mem[base+2];
      req_tag = next_tag;
      expected_sb[next_tag] = {pattern_mem[base+3], pattern_mem[base+4]};
      pending[next_tag] = 1'b1;
      req_credits--;
      sent++;
      next_tag = next_tag + 4'd1;
    end else begin
      req_val = 1'b0;
    end
  endtask

  task automatic run_cycle();
    collect_response();
    return_resp_credit();
    issue_request();
    // a credit pulse this cycle is only spent from the next one on
    if (req_credit === 1'b1) begin
      req_credits++;
      if (req_credits > muldiv_pkg::REQ_CREDITS) begin
        $display("at %0t ns req_credit returned more credits than were spent", $time);
        protocol_errors++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d responses arrived in %0d ns",
             received, NUM_PATTERNS, WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    reset       = 1'b1;
    req_val     = 1'b0;
    req_op      = muldiv_pkg::OP_MUL;
    req_a       = '0;
    req_b       = '0;
    req_tag     = '0;
    resp_credit = 1'b0;
    next_tag    = '0;
    sent        = 0;
    received    = 0;
    req_credits = muldiv_pkg::REQ_CREDITS;
    resp_credit_mirror = muldiv_pkg::RESP_CREDITS;
    owed        = 0;
    draining    = 1'b0;
    credit_last = 1'b0;
    lfsr        = 16'd28260;
    value_errors    = 0;
    tag_errors      = 0;
    protocol_errors = 0;
    for (int i = 0; i < NUM_TAGS; i++) begin
      pending[i]     = 1'b0;
      expected_sb[i] = '0;
    end
    $readmemh("tb/muldiv_patterns.txt", pattern_mem);

    repeat (8) @(negedge clk);
    reset = 1'b0;

    while (received < NUM_PATTERNS) begin
      @(negedge clk);
      run_cycle();
    end
    // keep running so a late duplicate would still show up
    repeat (50) begin
      @(negedge clk);
      run_cycle();
    end

    if (req_credits != muldiv_pkg::REQ_CREDITS) begin
      $display("Error at %0t ns: req_credits got %0d expected %0d",
               $time, req_credits, muldiv_pkg::REQ_CREDITS);
      protocol_errors++;
    end

    $display("errors: %0d value, %0d tag, %0d protocol",
             value_errors, tag_errors, protocol_errors);
    if (value_errors == 0 && tag_errors == 0 && protocol_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tb/muldiv_patterns.txt ====
// op (0 mul, 1 div, 2 divu), a, b, expected[63:32], expected[31:0]
// divide results are {remainder, quotient}; mul and div lines alternate
0 00000003 00000007 00000000 00000015
1 00000014 00000003 00000002 00000006
0 fffffffd 00000007 ffffffff ffffffeb
1 ffffffec 00000003 fffffffe fffffffa
0 00000003 fffffff9 ffffffff ffffffeb
1 00000014 fffffffd 00000002 fffffffa
0 fffffffd fffffff9 00000000 00000015
1 ffffffec fffffffd fffffffe 00000006
0 80000000 80000000 40000000 00000000
1 80000000 ffffffff 00000000 80000000
0 7fffffff 7fffffff 3fffffff 00000001
1 00000007 00000000 00000007 ffffffff
0 80000000 7fffffff c0000000 80000000
1 fffffff9 00000000 fffffff9 ffffffff
0 00000000 12345678 00000000 00000000
2 ffffffff 00000002 00000001 7fffffff
0 ffffffff ffffffff 00000000 00000001
2 80000000 ffffffff 80000000 00000000
0 ffffffff 00000001 ffffffff ffffffff
2 12345678 00001000 00000678 00012345
0 00010000 00010000 00000001 00000000
2 deadbeef 00000000 deadbeef ffffffff
0 12345678 00000010 00000001 23456780
1 80000000 00000002 00000000 c0000000
0 80000000 ffffffff 00000000 80000000
2 fffffffe ffffffff fffffffe 00000000
0 80000000 00000001 ffffffff 80000000
1 00000005 0000000a 00000005 00000000
0 00000005 fffffffb ffffffff ffffffe7
2 00000064 00000007 00000002 0000000e

// ==== src.f ====
logic/muldiv_pkg.sv
logic/muldiv_unit_if.sv
logic/int_mul_iterative.sv
logic/int_div_iterative.sv
logic/muldiv_req_queue.sv
logic/muldiv_resp_arbiter.sv
logic/muldiv_top.sv
tb/muldiv_tb.sv

// ==== Makefile ====
# Verilator build and run of the muldiv testbench

SIM  := obj_dir/Vmuldiv_tb
SRCS := $(shell cat src.f)

.PHONY: run clean

# pass only when the pass line shows up in the simulator output
run: $(SIM) tb/muldiv_patterns.txt
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

# rebuilt only when a source or the file list changes
$(SIM): src.f $(SRCS)
	verilator --binary --timescale 1ns/1ps --top-module muldiv_tb -f src.f

clean:
	rm -rf obj_dir
